/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_matmul
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* hw/array_feed_if.sv */
`timescale 1ns/1ps

interface array_feed_if import mat_pkg::*; ();

  // Skewed operands entering the west and north edges
  row_t a_edge;
  row_t b_edge;

  // Shift and accumulate enable
  logic feed_en;

  // Zeroes every sum and forwarding register
  logic clear;

  modport source (
    output a_edge,
    output b_edge
  );

  modport steer (
    output feed_en,
    output clear
  );

  modport array (
    input a_edge,
    input b_edge,
    input feed_en,
    input clear
  );

endinterface

/* hw/mac_pe.sv */
`timescale 1ns/1ps

module mac_pe import mat_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  en,
  input  logic  clear,
  input  elem_t a_in,
  input  elem_t b_in,
  output elem_t a_out,
  output elem_t b_out,
  output sum_t  sum
);

  sum_t product;

  // 8 x 8 unsigned product, zero extended to the sum width
  assign product = ACC_W'(a_in) * ACC_W'(b_in);

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      sum   <= '0;
      a_out <= '0;
      b_out <= '0;
    end else if (en) begin
      sum   <= sum + product;
      // One hop per cycle to the east and south neighbors
      a_out <= a_in;
      b_out <= b_in;
    end
  end

endmodule

/* hw/mat_pkg.sv */
package mat_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Matrix order
  localparam int DIM = 4;

  // Unsigned operand width
  localparam int DATA_W = 8;

  // Wide enough for DIM products of 255 x 255
  localparam int ACC_W = 20;

  localparam int IDX_W = $clog2(DIM);

  // Last operand pair reaches cell (DIM-1, DIM-1) on the final step
  localparam int FEED_STEPS = 3 * DIM - 2;
  localparam int STEP_W = $clog2(FEED_STEPS);

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [DATA_W-1:0] elem_t;
  typedef elem_t [DIM-1:0] row_t;
  typedef logic [ACC_W-1:0] sum_t;
  typedef sum_t [DIM-1:0] sum_row_t;

  // Load opcode
  typedef enum logic {
    MAT_A,
    MAT_B
  } mat_sel_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CLEAR,
    ST_RUN,
    ST_CAPTURE,
    ST_DONE
  } ctrl_state_e;

endpackage

/* hw/matmul_ctrl.sv */
`timescale 1ns/1ps

module matmul_ctrl import mat_pkg::*; (
  input  logic               clk,
  input  logic               reset,

  // Four-phase start handshake
  input  logic               req,
  output logic               ack,

  // Step counter
  input  logic               last_step,
  output logic               cnt_run,

  // Result store load strobe
  output logic               capture,

  array_feed_if.steer        feed
);

  ctrl_state_e state;
  ctrl_state_e state_next;

  //////////////////////////////
  // State register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req) begin
          state_next = ST_CLEAR;
        end
      end
      // One cycle to wipe the previous run
      ST_CLEAR: begin
        state_next = ST_RUN;
      end
      ST_RUN: begin
        if (last_step) begin
          state_next = ST_CAPTURE;
        end
      end
      ST_CAPTURE: begin
        state_next = ST_DONE;
      end
      // Hold ack until the requester drops req
      ST_DONE: begin
        if (!req) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // Moore outputs, all low in idle
  assign feed.clear   = (state == ST_CLEAR);
  assign feed.feed_en = (state == ST_RUN);
  assign cnt_run      = (state == ST_RUN);
  assign capture      = (state == ST_CAPTURE);
  assign ack          = (state == ST_DONE);

endmodule

/* hw/matmul_top.sv */
`timescale 1ns/1ps

module matmul_top import mat_pkg::*; (
  input  logic             clk,
  input  logic             reset,

  // Row load port
  input  logic             load_en,
  input  mat_sel_e         load_sel,
  input  logic [IDX_W-1:0] load_row,
  input  row_t             load_data,

  // Start handshake
  input  logic             req,
  output logic             ack,

  // Result read port
  input  logic [IDX_W-1:0] rd_row,
  output sum_row_t         rd_data
);

  logic              cnt_run;
  logic              last_step;
  logic [STEP_W-1:0] step;
  logic              capture;
  sum_row_t [DIM-1:0] sums;

  array_feed_if feed_if ();

  //////////////////////////////
  // Control
  //////////////////////////////

  matmul_ctrl ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .ack       (ack),
    .last_step (last_step),
    .cnt_run   (cnt_run),
    .capture   (capture),
    .feed      (feed_if)
  );

  step_counter step_cnt_i (
    .clk       (clk),
    .reset     (reset),
    .cnt_run   (cnt_run),
    .step      (step),
    .last_step (last_step)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  operand_bank opnd_i (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_sel  (load_sel),
    .load_row  (load_row),
    .load_data (load_data),
    .step      (step),
    .feed      (feed_if)
  );

  systolic_array array_i (
    .clk   (clk),
    .reset (reset),
    .feed  (feed_if),
    .sums  (sums)
  );

  result_bank result_i (
    .clk     (clk),
    .reset   (reset),
    .capture (capture),
    .sums    (sums),
    .rd_row  (rd_row),
    .rd_data (rd_data)
  );

endmodule

/* hw/operand_bank.sv */
`timescale 1ns/1ps

module operand_bank import mat_pkg::*; (
  input  logic              clk,
  input  logic              reset,

  // Row write port
  input  logic              load_en,
  input  mat_sel_e          load_sel,
  input  logic [IDX_W-1:0]  load_row,
  input  row_t              load_data,

  // Current feed step
  input  logic [STEP_W-1:0] step,

  array_feed_if.source      feed
);

  // a_mem[i][k] is A[i][k], b_mem[k][j] is B[k][j]
  row_t a_mem [DIM];
  row_t b_mem [DIM];

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < DIM; r++) begin
        a_mem[r] <= '0;
        b_mem[r] <= '0;
      end
    end else if (load_en) begin
      if (load_sel == MAT_A) begin
        a_mem[load_row] <= load_data;
      end else begin
        b_mem[load_row] <= load_data;
      end
    end
  end

  //////////////////////////////
  // Skewed edge feed
  //////////////////////////////

  // Row i and column j start i or j steps late, zero outside the matrix
  always_comb begin
    int idx;
    feed.a_edge = '0;
    feed.b_edge = '0;
    for (int n = 0; n < DIM; n++) begin
      idx = int'(step) - n;
      if (idx >= 0 && idx < DIM) begin
        feed.a_edge[n] = a_mem[n][idx[IDX_W-1:0]];
        feed.b_edge[n] = b_mem[idx[IDX_W-1:0]][n];
      end
    end
  end

endmodule

/* hw/result_bank.sv */
`timescale 1ns/1ps

module result_bank import mat_pkg::*; (
  input  logic               clk,
  input  logic               reset,

  // Snapshot strobe at the end of a run
  input  logic               capture,
  input  sum_row_t [DIM-1:0] sums,

  // Row read port
  input  logic [IDX_W-1:0]   rd_row,
  output sum_row_t           rd_data
);

  //////////////////////////////
  // Result registers
  //////////////////////////////

  // Holds C of the last captured run
  sum_row_t [DIM-1:0] results;

  always_ff @(posedge clk) begin
    if (reset) begin
      results <= '0;
    end else if (capture) begin
      results <= sums;
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////

  // Combinational row select
  assign rd_data = results[rd_row];

endmodule

/* hw/step_counter.sv */
`timescale 1ns/1ps

module step_counter import mat_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              cnt_run,
  output logic [STEP_W-1:0] step,
  output logic              last_step
);

  logic [STEP_W-1:0] count;

  // Counts feed steps, parks at zero between runs
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (cnt_run) begin
      count <= count + 1'b1;
    end else begin
      count <= '0;
    end
  end

  assign step = count;

  // Final feed step
  assign last_step = (count == STEP_W'(FEED_STEPS - 1));

endmodule

/* hw/systolic_array.sv */
`timescale 1ns/1ps

module systolic_array import mat_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  array_feed_if.array        feed,
  output sum_row_t [DIM-1:0] sums
);

  // Operands into and out of each cell
  elem_t a_in  [DIM][DIM];
  elem_t b_in  [DIM][DIM];
  elem_t a_out [DIM][DIM];
  elem_t b_out [DIM][DIM];

  for (genvar i = 0; i < DIM; i++) begin : g_row
    for (genvar j = 0; j < DIM; j++) begin : g_col

      // A moves east along the row
      if (j == 0) begin : g_west
        assign a_in[i][j] = feed.a_edge[i];
      end else begin : g_a_link
        assign a_in[i][j] = a_out[i][j-1];
      end

      // B moves south down the column
      if (i == 0) begin : g_north
        assign b_in[i][j] = feed.b_edge[j];
      end else begin : g_b_link
        assign b_in[i][j] = b_out[i-1][j];
      end

      mac_pe pe_i (
        .clk   (clk),
        .reset (reset),
        .en    (feed.feed_en),
        .clear (feed.clear),
        .a_in  (a_in[i][j]),
        .b_in  (b_in[i][j]),
        .a_out (a_out[i][j]),
        .b_out (b_out[i][j]),
        .sum   (sums[i][j])
      );

    end
  end

endmodule

/* sim/tb_matmul.sv */
`timescale 1ns/1ps

module tb_matmul import mat_pkg::*; ();

  // Edges from sampling req in idle to ack high
  localparam int ACK_LATENCY = 13;
  localparam int ACK_TIMEOUT = 50;
  localparam int HOLD_CYCLES = 4;
  localparam int RANDOM_RUNS = 20;

  logic             clk;
  logic             reset;
  logic             load_en;
  mat_sel_e         load_sel;
  logic [IDX_W-1:0] load_row;
  row_t             load_data;
  logic             req;
  logic             ack;
  logic [IDX_W-1:0] rd_row;
  sum_row_t         rd_data;

  // Reference matrices and expected product
  int unsigned a_m [DIM][DIM];
  int unsigned b_m [DIM][DIM];
  int unsigned c_m [DIM][DIM];

  matmul_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_sel  (load_sel),
    .load_row  (load_row),
    .load_data (load_data),
    .req       (req),
    .ack       (ack),
    .rd_row    (rd_row),
    .rd_data   (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Drive point shortly after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s actual 0x%0h expected 0x%0h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic wait_ack(input logic level, output int cycles);
    cycles = 0;
    while (ack !== level && cycles < ACK_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    if (ack !== level) begin
      $display("Timed out waiting for ack to go %0s", level ? "high" : "low");
      abort_run();
    end
  endtask

  // Writes one matrix from the model a row at a time
  task automatic load_matrix(input mat_sel_e sel);
    row_t row;
    for (int r = 0; r < DIM; r++) begin
      for (int k = 0; k < DIM; k++) begin
        row[k] = (sel == MAT_A) ? elem_t'(a_m[r][k]) : elem_t'(b_m[r][k]);
      end
      load_en   = 1'b1;
      load_sel  = sel;
      load_row  = IDX_W'(r);
      load_data = row;
      next_cycle();
    end
    load_en = 1'b0;
  endtask

  task automatic random_operands();
    for (int i = 0; i < DIM; i++) begin
      for (int k = 0; k < DIM; k++) begin
        a_m[i][k] = $urandom % 256;
        b_m[i][k] = $urandom % 256;
      end
    end
  endtask

  // C = A x B in plain integer arithmetic
  task automatic compute_model();
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) begin
        c_m[i][j] = 0;
        for (int k = 0; k < DIM; k++) begin
          c_m[i][j] += a_m[i][k] * b_m[k][j];
        end
      end
    end
  endtask

  // One full four-phase handshake
  task automatic run_multiply();
    int cycles;
    check("ack before req", 32'(ack), 0);
    req = 1'b1;
    wait_ack(1'b1, cycles);
    check("ack latency", cycles, ACK_LATENCY);
    repeat (HOLD_CYCLES) begin
      next_cycle();
      check("ack while req held", 32'(ack), 1);
    end
    req = 1'b0;
    wait_ack(1'b0, cycles);
    check("ack release delay", cycles, 1);
  endtask

  task automatic check_results();
    for (int r = 0; r < DIM; r++) begin
      rd_row = IDX_W'(r);
      #1;
      for (int j = 0; j < DIM; j++) begin
        check($sformatf("rd_data row %0d col %0d", r, j), 32'(rd_data[j]), c_m[r][j]);
      end
      next_cycle();
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    void'($urandom(32'h5be0));
    reset     = 1'b1;
    load_en   = 1'b0;
    load_sel  = MAT_A;
    load_row  = '0;
    load_data = '0;
    req       = 1'b0;
    rd_row    = '0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    // Results start cleared
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) begin
        c_m[i][j] = 0;
      end
    end
    check("ack after reset", 32'(ack), 0);
    check_results();

    // Largest operands with no overflow expected
    for (int i = 0; i < DIM; i++) begin
      for (int k = 0; k < DIM; k++) begin
        a_m[i][k] = 255;
        b_m[i][k] = 255;
      end
    end
    load_matrix(MAT_A);
    load_matrix(MAT_B);
    compute_model();
    run_multiply();
    check_results();

    // Identity A gives C equal to B with nothing left from the big sums
    random_operands();
    for (int i = 0; i < DIM; i++) begin
      for (int k = 0; k < DIM; k++) begin
        a_m[i][k] = (i == k) ? 1 : 0;
      end
    end
    load_matrix(MAT_A);
    load_matrix(MAT_B);
    compute_model();
    run_multiply();
    check_results();

    // Back-to-back random runs
    for (int n = 0; n < RANDOM_RUNS; n++) begin
      random_operands();
      load_matrix(MAT_A);
      load_matrix(MAT_B);
      compute_model();
      run_multiply();
      check_results();
    end

    // New operands alone must not disturb the stored product
    random_operands();
    load_matrix(MAT_A);
    load_matrix(MAT_B);
    check_results();
    compute_model();
    run_multiply();
    check_results();

    $display("sim passed");
    $finish;
  end

endmodule

/* tb.f */
hw/mat_pkg.sv
hw/array_feed_if.sv
hw/mac_pe.sv
hw/systolic_array.sv
hw/step_counter.sv
hw/operand_bank.sv
hw/result_bank.sv
hw/matmul_ctrl.sv
hw/matmul_top.sv
sim/tb_matmul.sv
